/* files.f */
logic/deskew_pkg.sv
logic/pixel_scan.sv
logic/moment_pass_seq.sv
logic/centroid_div_seq.sv
logic/skew_seq.sv
logic/resample_seq.sv
logic/deskew_ctrl.sv
tb/tb_deskew_ctrl.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module tb_deskew_ctrl -f files.f -Mdir obj_dir -o sim_deskew \
   && ./obj_dir/sim_deskew > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "PASS: all tests" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tb/tb_deskew_ctrl.sv */
module tb_deskew_ctrl;

   localparam int PERIOD     = 8;
   localparam int RESET_CYC  = 16;
   localparam int MAX_DLY    = 8;    // divider result delay of 1..MAX_DLY cycles
   localparam int READY_WAIT = 64;   // allowance for random ready stalls
   localparam int IDLE_CYC   = 12;
   localparam logic [31:0] SEED = 32'ha64e_7da6;

   // img_dim of every frame the tests run in order
   localparam int N_FRAMES = 9;
   localparam int FRAME_DIMS [N_FRAMES] = '{4, 5, 4, 4, 4, 4, 4, 5, 4};

   logic clk = 1'b0;
   logic rst_n;
   logic [deskew_pkg::DIM_W-1:0] img_dim;
   logic start;
   logic div_res_vld  = 1'b0;
   logic skew_dvd_rdy = 1'b0;
   logic skew_dvs_rdy = 1'b0;
   logic skew_res_vld = 1'b0;
   logic signed [deskew_pkg::COORD_W-1:0] xp_r = '0;

   logic busy, deskew_done;
   logic m_clr, m_scan_en, m_accum_en;
   logic div_valid, div_sel, x_mc_en, y_mc_en;
   logic mu_clr, mu_scan_en, mu_accum_en;
   logic skew_vld, skew_r_en, m02_mult_en, m02_r_en;
   logic xp_gen_en, p_addr_en, pix_rd_en, p_rd_sel, interp_en;
   logic p_r_en, p_val_sel, pix_wr_en;

   string       test_name = "none";
   int          err_cnt   = 0;
   logic [31:0] rng       = SEED;

   // values from the previous negedge
   logic p_busy = 1'b0, p_m_scan = 1'b0, p_m_accum = 1'b0;
   logic p_mu_scan = 1'b0, p_mu_accum = 1'b0;
   logic p_div_res = 1'b0, p_x_mc = 1'b0, p_skew_vld = 1'b0;
   logic p_both_rdy = 1'b0, p_skew_res = 1'b0, p_done = 1'b0;
   logic exp_in = 1'b0;

   int cyc = 0;
   int m_rise = 0, mu_rise = 0, m_len = 0, mu_len = 0, mult_len = 0, rd_cnt = 0;
   int div_cnt = 0, skew_cnt = 0;

   // per-frame counts cleared when busy rises
   int n_m_burst = 0, n_mu_burst = 0, n_acc_rise = 0;
   int n_div_valid = 0, n_x_mc = 0, n_y_mc = 0;
   int n_skew_rise = 0, n_mult = 0;
   int n_wr = 0, n_in = 0, n_out = 0, n_done = 0;

   deskew_ctrl i_deskew_ctrl (.*);

   always #(PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // negative, inside and too large source coordinates
   function automatic int pick_coord(input logic [31:0] r, input int dim);
      case (r[1:0])
         2'd0:    return -1 - int'(r[5:2]);
         2'd3:    return dim - 1 + int'(r[5:2]);   // dim-1 is already outside
         default: return int'(r[15:8]) % (dim - 1);
      endcase
   endfunction

   function automatic int frame_cycles(input int dim);
      int pix;
      pix = dim * dim;
      return 2 * (pix + deskew_pkg::MU_FEED_LAT + 4)
           + 2 * (MAX_DLY + 6) + READY_WAIT + deskew_pkg::M02_LAT + 4
           + pix * (8 + deskew_pkg::P_MULT_LAT + 1)   // inside-image pixel
           + IDLE_CYC + 20;
   endfunction

   function automatic void clear_counts();
      n_m_burst   = 0;
      n_mu_burst  = 0;
      n_acc_rise  = 0;
      n_div_valid = 0;
      n_x_mc      = 0;
      n_y_mc      = 0;
      n_skew_rise = 0;
      n_mult      = 0;
      n_wr        = 0;
      n_in        = 0;
      n_out       = 0;
      n_done      = 0;
   endfunction

   task automatic check_eq(input string what, input int exp_v, input int act_v);
      if (exp_v != act_v)
      begin
         err_cnt++;
         $display("Mismatch in %s (%s): expected %0d, actual %0d",
                  test_name, what, exp_v, act_v);
         $display("FAIL: see errors above");
         $fatal(1, "stopped at first error");
      end
   endtask

   // monitor and responder models at the falling edge
   always @(negedge clk)
   begin
      int dim_sq;
      int v;
      dim_sq = int'(img_dim) * int'(img_dim);
      cyc++;
      if (busy && !p_busy)
         clear_counts();

      if (m_scan_en)
         m_len++;
      if (m_scan_en && !p_m_scan)
         m_rise = cyc;
      if (p_m_scan && !m_scan_en)
      begin
         check_eq("m_scan_en length", dim_sq, m_len);
         m_len = 0;
         n_m_burst++;
      end
      if (m_accum_en && !p_m_accum)
      begin
         check_eq("m_accum_en delay", deskew_pkg::RAW_FEED_LAT, cyc - m_rise);
         n_acc_rise++;
      end

      if (mu_scan_en)
         mu_len++;
      if (mu_scan_en && !p_mu_scan)
         mu_rise = cyc;
      if (p_mu_scan && !mu_scan_en)
      begin
         check_eq("mu_scan_en length", dim_sq, mu_len);
         mu_len = 0;
         n_mu_burst++;
      end
      if (mu_accum_en && !p_mu_accum)
      begin
         check_eq("mu_accum_en delay", deskew_pkg::MU_FEED_LAT, cyc - mu_rise);
         n_acc_rise++;
      end

      check_eq("x_mc_en after div_res_vld", int'(p_div_res), int'(x_mc_en));
      check_eq("y_mc_en after x_mc_en", int'(p_x_mc), int'(y_mc_en));
      if (div_valid)
      begin
         check_eq("div_sel with div_valid", 0, int'(div_sel));
         n_div_valid++;
      end
      if (x_mc_en)
         n_x_mc++;
      if (y_mc_en)
         n_y_mc++;

      if (p_skew_vld)
         check_eq("skew_vld release", int'(!p_both_rdy), int'(skew_vld));
      if (skew_vld && !p_skew_vld)
         n_skew_rise++;
      check_eq("skew_r_en after skew_res_vld", int'(p_skew_res), int'(skew_r_en));
      if (m02_mult_en)
         mult_len++;
      else if (mult_len != 0)
      begin
         check_eq("m02_mult_en length", deskew_pkg::M02_LAT + 1, mult_len);
         mult_len = 0;
         n_mult++;
      end

      if (pix_rd_en)
         rd_cnt++;
      if (p_r_en)
      begin
         check_eq("p_val_sel", int'(exp_in), int'(p_val_sel));
         check_eq("pix_rd_en cycles", exp_in ? 2 : 0, rd_cnt);
         if (exp_in)
            n_in++;
         else
            n_out++;
      end
      if (pix_wr_en)
         n_wr++;
      if (deskew_done)
         n_done++;
      if (p_done)
         check_eq("busy after deskew_done", 0, int'(busy));

      // drive the next inputs
      rng = xorshift32(rng);
      skew_dvd_rdy = rng[4];
      skew_dvs_rdy = rng[9];
      div_res_vld  = 1'b0;
      if (div_cnt != 0)
      begin
         div_cnt--;
         div_res_vld = (div_cnt == 0);
      end
      if (div_valid)
         div_cnt = 1 + int'(rng[14:12]);   // 1..MAX_DLY
      skew_res_vld = 1'b0;
      if (skew_cnt != 0)
      begin
         skew_cnt--;
         skew_res_vld = (skew_cnt == 0);
      end
      if (p_skew_vld && !skew_vld)
         skew_cnt = 1 + int'(rng[19:17]);
      if (xp_gen_en)
      begin
         rng = xorshift32(rng);
         v = pick_coord(rng, int'(img_dim));
         xp_r = v[deskew_pkg::COORD_W-1:0];
         exp_in = (v >= 0) && (v < int'(img_dim) - 1);
         rd_cnt = 0;
      end

      p_busy     = busy;
      p_m_scan   = m_scan_en;
      p_m_accum  = m_accum_en;
      p_mu_scan  = mu_scan_en;
      p_mu_accum = mu_accum_en;
      p_div_res  = div_res_vld;
      p_x_mc     = x_mc_en;
      p_skew_vld = skew_vld;
      p_both_rdy = skew_dvd_rdy && skew_dvs_rdy;
      p_skew_res = skew_res_vld;
      p_done     = deskew_done;
   end

   // one frame with an optional second start while resampling
   task automatic run_frame(input int dim, input bit second_start);
      @(negedge clk);
      img_dim = deskew_pkg::DIM_W'(dim);
      start   = 1'b1;
      @(negedge clk);
      start = 1'b0;
      check_eq("busy after start", 1, int'(busy));
      if (second_start)
      begin
         while (!xp_gen_en)
            @(negedge clk);
         start = 1'b1;   // raw pass is idle here
         @(negedge clk);
         start = 1'b0;
      end
      @(negedge clk);
      while (n_done == 0)
         @(negedge clk);
      repeat (IDLE_CYC) @(negedge clk);
      check_eq("deskew_done pulses", 1, n_done);
      check_eq("pix_wr_en pulses", dim * dim, n_wr);
      check_eq("busy after frame", 0, int'(busy));
   endtask

   task automatic test_reset_state();
      test_name = "reset_state";
      @(negedge clk);
      check_eq("outputs after reset", 0, int'({busy, deskew_done, m_clr, m_scan_en,
         m_accum_en, div_valid, div_sel, x_mc_en, y_mc_en, mu_clr, mu_scan_en,
         mu_accum_en, skew_vld, skew_r_en, m02_mult_en, m02_r_en, xp_gen_en,
         p_addr_en, pix_rd_en, p_rd_sel, interp_en, p_r_en, p_val_sel, pix_wr_en}));
   endtask

   task automatic test_raster(input int dim);
      test_name = $sformatf("raster_%0d", dim);
      run_frame(dim, 1'b0);
      check_eq("m_scan_en bursts", 1, n_m_burst);
      check_eq("mu_scan_en bursts", 1, n_mu_burst);
      check_eq("accum_en rises", 2, n_acc_rise);
   endtask

   task automatic test_centroid();
      test_name = "centroid";
      repeat (3)
      begin
         run_frame(4, 1'b0);
         check_eq("div_valid pulses", 1, n_div_valid);
         check_eq("x_mc_en pulses", 1, n_x_mc);
         check_eq("y_mc_en pulses", 1, n_y_mc);
      end
   endtask

   task automatic test_skew();
      test_name = "skew";
      repeat (2)
      begin
         run_frame(4, 1'b0);
         check_eq("skew_vld rises", 1, n_skew_rise);
         check_eq("m02_mult_en bursts", 1, n_mult);
      end
   endtask

   task automatic test_resample(input int dim);
      test_name = "resample";
      run_frame(dim, 1'b0);
      check_eq("p_r_en pulses", dim * dim, n_in + n_out);
      check_eq("inside pixels seen", 1, int'(n_in > 0));
      check_eq("outside pixels seen", 1, int'(n_out > 0));
   endtask

   task automatic test_frame_ctrl();
      test_name = "frame_ctrl";
      run_frame(4, 1'b1);
      check_eq("raw passes", 1, n_m_burst);
   endtask

   initial
   begin
      int limit;
      limit = RESET_CYC + 20;
      for (int i = 0; i < N_FRAMES; i++)
         limit = limit + frame_cycles(FRAME_DIMS[i]);
      limit = 2 * limit;
      #(limit * PERIOD);
      $display("Timeout: the frames did not finish within %0d cycles", limit);
      $display("FAIL: see errors above");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      rst_n   = 1'b0;
      start   = 1'b0;
      img_dim = deskew_pkg::DIM_W'(4);
      repeat (RESET_CYC) @(negedge clk);
      rst_n = 1'b1;

      test_reset_state();
      test_raster(4);
      test_raster(5);
      test_centroid();
      test_skew();
      test_resample(5);
      test_frame_ctrl();

      if (err_cnt == 0)
      begin
         $display("PASS: all tests");
         $finish;
      end
      else
      begin
         $display("FAIL: see errors above");
         $fatal(1, "errors found");
      end
   end

endmodule

/* logic/deskew_ctrl.sv */
module deskew_ctrl
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic [deskew_pkg::DIM_W-1:0]          img_dim,
   input  logic                                 start,
   input  logic                                 div_res_vld,
   input  logic                                 skew_dvd_rdy,
   input  logic                                 skew_dvs_rdy,
   input  logic                                 skew_res_vld,
   input  logic signed [deskew_pkg::COORD_W-1:0] xp_r,
   output logic                                 busy,
   output logic                                 deskew_done,
   output logic                                 m_clr,
   output logic                                 m_scan_en,
   output logic                                 m_accum_en,
   output logic                                 div_valid,
   output logic                                 div_sel,
   output logic                                 x_mc_en,
   output logic                                 y_mc_en,
   output logic                                 mu_clr,
   output logic                                 mu_scan_en,
   output logic                                 mu_accum_en,
   output logic                                 skew_vld,
   output logic                                 skew_r_en,
   output logic                                 m02_mult_en,
   output logic                                 m02_r_en,
   output logic                                 xp_gen_en,
   output logic                                 p_addr_en,
   output logic                                 pix_rd_en,
   output logic                                 p_rd_sel,
   output logic                                 interp_en,
   output logic                                 p_r_en,
   output logic                                 p_val_sel,
   output logic                                 pix_wr_en
);

   logic start_ok;   // start taken only between frames
   logic raw_done;
   logic cen_done;
   logic mu_done;
   logic skew_done;

   assign start_ok = start && !busy;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         busy <= 1'b0;
      else if (start_ok)
         busy <= 1'b1;
      else if (deskew_done)
         busy <= 1'b0;
   end

   moment_pass_seq #(.FEED_LAT(deskew_pkg::RAW_FEED_LAT)) i_raw_pass
   (
      .clk (clk), .rst_n (rst_n), .img_dim (img_dim), .start (start_ok),
      .clr (m_clr), .scan_en (m_scan_en), .accum_en (m_accum_en), .done (raw_done)
   );

   centroid_div_seq i_centroid
   (
      .clk (clk), .rst_n (rst_n), .start (raw_done), .div_res_vld (div_res_vld),
      .div_valid (div_valid), .div_sel (div_sel), .x_mc_en (x_mc_en),
      .y_mc_en (y_mc_en), .done (cen_done)
   );

   // central moments reuse the pass sequencer with the longer subtract path
   moment_pass_seq #(.FEED_LAT(deskew_pkg::MU_FEED_LAT)) i_mu_pass
   (
      .clk (clk), .rst_n (rst_n), .img_dim (img_dim), .start (cen_done),
      .clr (mu_clr), .scan_en (mu_scan_en), .accum_en (mu_accum_en), .done (mu_done)
   );

   skew_seq i_skew
   (
      .clk (clk), .rst_n (rst_n), .start (mu_done),
      .skew_dvd_rdy (skew_dvd_rdy), .skew_dvs_rdy (skew_dvs_rdy),
      .skew_res_vld (skew_res_vld), .skew_vld (skew_vld), .skew_r_en (skew_r_en),
      .m02_mult_en (m02_mult_en), .m02_r_en (m02_r_en), .done (skew_done)
   );

   resample_seq i_resample
   (
      .clk (clk), .rst_n (rst_n), .img_dim (img_dim), .start (skew_done), .xp_r (xp_r),
      .xp_gen_en (xp_gen_en), .p_addr_en (p_addr_en), .pix_rd_en (pix_rd_en),
      .p_rd_sel (p_rd_sel), .interp_en (interp_en), .p_r_en (p_r_en),
      .p_val_sel (p_val_sel), .pix_wr_en (pix_wr_en), .done (deskew_done)
   );

endmodule

/* logic/resample_seq.sv */
module resample_seq
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic [deskew_pkg::DIM_W-1:0]          img_dim,
   input  logic                                 start,
   input  logic signed [deskew_pkg::COORD_W-1:0] xp_r,
   output logic                                 xp_gen_en,
   output logic                                 p_addr_en,
   output logic                                 pix_rd_en,
   output logic                                 p_rd_sel,
   output logic                                 interp_en,
   output logic                                 p_r_en,
   output logic                                 p_val_sel,
   output logic                                 pix_wr_en,
   output logic                                 done
);

   typedef enum logic [3:0]
   {
      IDLE, GEN, WAIT_XP, CHECK, ADDR, RD0, RD1, INTERP, PVAL, WRITE
   } rs_state_t;

   rs_state_t                      state;
   logic [deskew_pkg::P_CNT_W-1:0] cnt;
   logic [deskew_pkg::COORD_W-1:0] dim_lim;
   logic                           in_img;
   logic                           last;

   assign dim_lim = {{(deskew_pkg::COORD_W - deskew_pkg::DIM_W){1'b0}}, img_dim} - 1'b1;
   assign in_img  = !xp_r[deskew_pkg::COORD_W-1] && ($unsigned(xp_r) < dim_lim);

   // output pixel position
   pixel_scan i_out_scan
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .clr     (start),
      .step    (pix_wr_en),
      .img_dim (img_dim),
      .x_cnt   (),
      .y_cnt   (),
      .last    (last)
   );

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= IDLE;
         cnt       <= '0;
         xp_gen_en <= 1'b0;
         p_addr_en <= 1'b0;
         pix_rd_en <= 1'b0;
         p_rd_sel  <= 1'b0;
         interp_en <= 1'b0;
         p_r_en    <= 1'b0;
         p_val_sel <= 1'b0;
         pix_wr_en <= 1'b0;
         done      <= 1'b0;
      end
      else
      begin
         xp_gen_en <= 1'b0;
         p_addr_en <= 1'b0;
         p_r_en    <= 1'b0;
         pix_wr_en <= 1'b0;
         done      <= 1'b0;
         case (state)
            IDLE:
               if (start)
               begin
                  xp_gen_en <= 1'b1;
                  state     <= GEN;
               end
            GEN:     state <= WAIT_XP;
            WAIT_XP: state <= CHECK;   // xp_r valid from here on
            CHECK:
               if (in_img)
               begin
                  p_addr_en <= 1'b1;
                  state     <= ADDR;
               end
               else
               begin
                  p_r_en    <= 1'b1;   // fill value
                  p_val_sel <= 1'b0;
                  state     <= PVAL;
               end
            ADDR:
            begin
               pix_rd_en <= 1'b1;
               p_rd_sel  <= 1'b0;
               state     <= RD0;
            end
            RD0:
            begin
               p_rd_sel <= 1'b1;   // second neighbour
               state    <= RD1;
            end
            RD1:
            begin
               pix_rd_en <= 1'b0;
               p_rd_sel  <= 1'b0;
               interp_en <= 1'b1;
               cnt       <= '0;
               state     <= INTERP;
            end
            INTERP:
               if (cnt == deskew_pkg::P_CNT_MAX)
               begin
                  interp_en <= 1'b0;
                  p_r_en    <= 1'b1;
                  p_val_sel <= 1'b1;
                  state     <= PVAL;
               end
               else
                  cnt <= cnt + 1'b1;
            PVAL:
            begin
               pix_wr_en <= 1'b1;
               state     <= WRITE;
            end
            default:
               if (last)
               begin
                  done  <= 1'b1;
                  state <= IDLE;
               end
               else
               begin
                  xp_gen_en <= 1'b1;
                  state     <= GEN;
               end
         endcase
      end
   end

   a_pval_interp: assert property (@(posedge clk) disable iff (!rst_n)
      !(p_r_en && interp_en));

endmodule

/* logic/skew_seq.sv */
module skew_seq
(
   input  logic clk,
   input  logic rst_n,
   input  logic start,
   input  logic skew_dvd_rdy,
   input  logic skew_dvs_rdy,
   input  logic skew_res_vld,
   output logic skew_vld,
   output logic skew_r_en,
   output logic m02_mult_en,
   output logic m02_r_en,
   output logic done
);

   typedef enum logic [2:0] {IDLE, PRESENT, WAIT_RES, SKEW_ST, MULT, M02_ST} skew_state_t;

   skew_state_t                      state;
   logic [deskew_pkg::M02_CNT_W-1:0] cnt;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state       <= IDLE;
         cnt         <= '0;
         skew_vld    <= 1'b0;
         skew_r_en   <= 1'b0;
         m02_mult_en <= 1'b0;
         m02_r_en    <= 1'b0;
         done        <= 1'b0;
      end
      else
      begin
         skew_r_en <= 1'b0;
         m02_r_en  <= 1'b0;
         done      <= 1'b0;
         case (state)
            IDLE:
               if (start)
               begin
                  skew_vld <= 1'b1;
                  state    <= PRESENT;
               end
            PRESENT:
               if (skew_dvd_rdy && skew_dvs_rdy)   // both divider ports take the operands
               begin
                  skew_vld <= 1'b0;
                  state    <= WAIT_RES;
               end
            WAIT_RES:
               if (skew_res_vld)
               begin
                  skew_r_en <= 1'b1;
                  state     <= SKEW_ST;
               end
            SKEW_ST:
            begin
               m02_mult_en <= 1'b1;
               cnt         <= '0;
               state       <= MULT;
            end
            MULT:
               if (cnt == deskew_pkg::M02_CNT_MAX)
               begin
                  m02_mult_en <= 1'b0;
                  m02_r_en    <= 1'b1;   // product settled
                  state       <= M02_ST;
               end
               else
                  cnt <= cnt + 1'b1;
            default:
            begin
               done  <= 1'b1;
               state <= IDLE;
            end
         endcase
      end
   end

   a_skew_hold: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(skew_vld) |-> $past(skew_dvd_rdy && skew_dvs_rdy));

endmodule

/* logic/centroid_div_seq.sv */
module centroid_div_seq
(
   input  logic clk,
   input  logic rst_n,
   input  logic start,
   input  logic div_res_vld,
   output logic div_valid,
   output logic div_sel,
   output logic x_mc_en,
   output logic y_mc_en,
   output logic done
);

   typedef enum logic [2:0] {IDLE, LAUNCH, WAIT_RES, X_CAP, Y_CAP} cen_state_t;

   cen_state_t state;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= IDLE;
         div_valid <= 1'b0;
         div_sel   <= 1'b0;
         x_mc_en   <= 1'b0;
         y_mc_en   <= 1'b0;
         done      <= 1'b0;
      end
      else
      begin
         div_valid <= 1'b0;
         x_mc_en   <= 1'b0;
         y_mc_en   <= 1'b0;
         done      <= 1'b0;
         case (state)
            IDLE:
               if (start)
               begin
                  div_valid <= 1'b1;   // operands for x go out with sel 0
                  div_sel   <= 1'b0;
                  state     <= LAUNCH;
               end
            LAUNCH:
            begin
               div_sel <= 1'b1;
               state   <= WAIT_RES;
            end
            WAIT_RES:
               if (div_res_vld)
               begin
                  x_mc_en <= 1'b1;
                  state   <= X_CAP;
               end
            X_CAP:
            begin
               y_mc_en <= 1'b1;   // y quotient one cycle behind x
               done    <= 1'b1;
               state   <= Y_CAP;
            end
            default:
            begin
               div_sel <= 1'b0;
               state   <= IDLE;
            end
         endcase
      end
   end

endmodule

/* logic/moment_pass_seq.sv */
module moment_pass_seq
#(
   parameter int FEED_LAT = deskew_pkg::RAW_FEED_LAT
)
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [deskew_pkg::DIM_W-1:0] img_dim,
   input  logic                        start,
   output logic                        clr,
   output logic                        scan_en,
   output logic                        accum_en,
   output logic                        done
);

   logic                active;
   logic                last;
   logic [FEED_LAT-1:0] feed_sr;    // scan_en delayed through the read pipeline
   logic [FEED_LAT:0]   feed_tap;

   assign feed_tap = {feed_sr, scan_en};
   assign accum_en = feed_tap[FEED_LAT];

   pixel_scan i_scan
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .clr     (clr),
      .step    (scan_en),
      .img_dim (img_dim),
      .x_cnt   (),
      .y_cnt   (),
      .last    (last)
   );

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         active  <= 1'b0;
         clr     <= 1'b0;
         scan_en <= 1'b0;
         feed_sr <= '0;
         done    <= 1'b0;
      end
      else
      begin
         clr     <= start && !active;
         feed_sr <= feed_tap[FEED_LAT-1:0];
         done    <= feed_tap[FEED_LAT] && !feed_tap[FEED_LAT-1];   // accum_en about to fall

         if (start && !active)
            active <= 1'b1;
         else if (feed_tap[FEED_LAT] && !feed_tap[FEED_LAT-1])
            active <= 1'b0;

         if (clr)
            scan_en <= 1'b1;
         else if (scan_en && last)
            scan_en <= 1'b0;
      end
   end

   // accumulation only ever belongs to a started pass
   a_accum_started: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(accum_en) |-> active);

endmodule

/* logic/pixel_scan.sv */
module pixel_scan
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        clr,
   input  logic                        step,
   input  logic [deskew_pkg::DIM_W-1:0] img_dim,
   output logic [deskew_pkg::DIM_W-1:0] x_cnt,
   output logic [deskew_pkg::DIM_W-1:0] y_cnt,
   output logic                        last
);

   logic [deskew_pkg::DIM_W-1:0] dim_m1;

   assign dim_m1 = img_dim - 1'b1;
   assign last   = (x_cnt == dim_m1) && (y_cnt == dim_m1);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         x_cnt <= '0;
         y_cnt <= '0;
      end
      else if (clr)
      begin
         x_cnt <= '0;
         y_cnt <= '0;
      end
      else if (step)
      begin
         if (x_cnt == dim_m1)
         begin
            x_cnt <= '0;
            y_cnt <= last ? '0 : y_cnt + 1'b1;   // wrap back to origin after last pixel
         end
         else
            x_cnt <= x_cnt + 1'b1;
      end
   end

   a_dim_min: assert property (@(posedge clk) disable iff (!rst_n)
      step |-> img_dim >= deskew_pkg::DIM_W'(2));

endmodule

/* logic/deskew_pkg.sv */
package deskew_pkg;

   // image side and pixel counter width
   localparam int DIM_W = 9;

   // signed source coordinate from the xp generator
   localparam int COORD_W = 15;

   // scan to accumulate delay per pass
   localparam int RAW_FEED_LAT = 2;
   localparam int MU_FEED_LAT  = 5;   // extra subtract stages

   // multiplier latencies
   localparam int M02_LAT    = 3;
   localparam int P_MULT_LAT = 2;

   // latency counters
   localparam int M02_CNT_W = $clog2(M02_LAT + 1);
   localparam int P_CNT_W   = $clog2(P_MULT_LAT + 1);

   localparam logic [M02_CNT_W-1:0] M02_CNT_MAX = M02_CNT_W'(M02_LAT);
   localparam logic [P_CNT_W-1:0]   P_CNT_MAX   = P_CNT_W'(P_MULT_LAT);

endpackage
